//--- logic/uart_pkg.sv
package uart_pkg;

	typedef enum logic [1:0] {
		PAR_NONE = 2'b00,
		PAR_RSVD = 2'b01, // treated as no parity
		PAR_ODD  = 2'b10,
		PAR_EVEN = 2'b11
	} parity_mode_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_PARITY,
		S_STOP
	} uart_state_e;

	typedef struct packed {
		logic         two_stop;
		logic         eight_bits;
		parity_mode_e parity_mode;
	} frame_fmt_t;

	typedef struct packed {
		logic       sel;
		logic       cmd; // control word, not data
		logic       wr;
		logic       rd;
		logic [7:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		frame_fmt_t fmt;
	} tx_load_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       parity_err;
		logic       frame_err;
	} rx_frame_t;

	// clocks per tick at 50 MHz, index 0 is 9600 baud
	localparam logic [3:0][8:0] BAUD_DIV = {9'd27, 9'd54, 9'd163, 9'd326};

	localparam int OVERSAMPLE = 16; // ticks per bit
	localparam int TICK_W = $clog2(OVERSAMPLE);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
	localparam logic [TICK_W-1:0] TICK_MID = TICK_W'(OVERSAMPLE / 2 - 1);

	localparam int TX_CREDITS = 1;
	localparam int CREDIT_W = $clog2(TX_CREDITS + 2); // one spare bit to see overflow

	localparam int MODE_BAUD = 0; // 2 bit field
	localparam int MODE_EIGHT = 2;
	localparam int MODE_TWO_STOP = 3;
	localparam int MODE_PARITY = 4; // 2 bit field

	localparam int CMD_RX_EN = 0;
	localparam int CMD_TX_EN = 1;
	localparam int CMD_PE_EN = 2;
	localparam int CMD_FE_EN = 3;
	localparam int CMD_OE_EN = 4;
	localparam int CMD_CLR_ERR = 5;

	localparam int ST_RX_RDY = 7;
	localparam int ST_TX_RDY = 6;
	localparam int ST_PE = 5;
	localparam int ST_FE = 4;
	localparam int ST_OE = 3;

endpackage

//--- logic/uart_host_regs.sv
`timescale 1ns/1ps

module uart_host_regs (
	input  logic                 clk_in,
	input  logic                 n_reset_in,
	input  uart_pkg::host_req_t  host_req,
	input  logic [7:0]           rx_data,
	input  logic                 rx_rdy,
	input  logic                 pe,
	input  logic                 fe,
	input  logic                 oe,
	input  logic                 tx_credit,
	output logic [7:0]           rd_data,
	output uart_pkg::frame_fmt_t fmt,
	output logic [1:0]           baud_sel,
	output uart_pkg::tx_load_t   tx_load,
	output logic                 tx_en,
	output logic                 rx_en,
	output logic                 err_clear,
	output logic                 take,
	output logic                 tx_rdy,
	output logic                 n_irq
);
	logic                            mode_done_r; // later control writes hit the command word
	logic [uart_pkg::CMD_OE_EN:0]    cmd_r;
	logic [uart_pkg::CREDIT_W-1:0]   credit_r;
	logic                            wr_ctl;
	logic                            wr_dat;
	logic                            rd_ctl;
	logic [7:0]                      status;
	uart_pkg::parity_mode_e          par_wr;

	assign wr_ctl = host_req.sel & host_req.cmd & host_req.wr;
	assign wr_dat = host_req.sel & ~host_req.cmd & host_req.wr;
	assign rd_ctl = host_req.sel & host_req.cmd & host_req.rd;
	assign take   = host_req.sel & ~host_req.cmd & host_req.rd;
	assign par_wr = uart_pkg::parity_mode_e'(host_req.wdata[uart_pkg::MODE_PARITY +: 2]);

	assign tx_en  = cmd_r[uart_pkg::CMD_TX_EN];
	assign rx_en  = cmd_r[uart_pkg::CMD_RX_EN];
	assign tx_rdy = (credit_r != '0) & tx_en;

	assign tx_load.valid = wr_dat & tx_rdy; // writes without a credit are dropped
	assign tx_load.data  = host_req.wdata;
	assign tx_load.fmt   = fmt;

	assign n_irq = ~((pe & cmd_r[uart_pkg::CMD_PE_EN]) | (fe & cmd_r[uart_pkg::CMD_FE_EN]) |
		(oe & cmd_r[uart_pkg::CMD_OE_EN]));

	always_ff @(posedge clk_in or negedge n_reset_in) begin
		if (!n_reset_in) begin
			mode_done_r <= 1'b0;
			baud_sel    <= '0;
			fmt         <= '0;
			cmd_r       <= '0;
			err_clear   <= 1'b0;
		end else begin
			err_clear <= wr_ctl & mode_done_r & host_req.wdata[uart_pkg::CMD_CLR_ERR];
			if (wr_ctl && !mode_done_r) begin
				mode_done_r     <= 1'b1;
				baud_sel        <= host_req.wdata[uart_pkg::MODE_BAUD +: 2];
				fmt.two_stop    <= host_req.wdata[uart_pkg::MODE_TWO_STOP];
				fmt.eight_bits  <= host_req.wdata[uart_pkg::MODE_EIGHT];
				fmt.parity_mode <= (par_wr == uart_pkg::PAR_RSVD) ? uart_pkg::PAR_NONE : par_wr;
			end else if (wr_ctl) begin
				cmd_r <= host_req.wdata[uart_pkg::CMD_OE_EN:0];
			end
		end
	end

	always_ff @(posedge clk_in or negedge n_reset_in) begin
		if (!n_reset_in) begin
			credit_r <= uart_pkg::TX_CREDITS[uart_pkg::CREDIT_W-1:0];
		end else begin
			case ({tx_load.valid, tx_credit})
				2'b10: credit_r <= credit_r - 1'b1; // byte handed to tx
				2'b01: credit_r <= credit_r + 1'b1; // frame done
				default: ;
			endcase
		end
	end

	always_comb begin
		status = '0;
		status[uart_pkg::ST_RX_RDY] = rx_rdy;
		status[uart_pkg::ST_TX_RDY] = tx_rdy;
		status[uart_pkg::ST_PE]     = pe;
		status[uart_pkg::ST_FE]     = fe;
		status[uart_pkg::ST_OE]     = oe;
	end

	always_ff @(posedge clk_in) begin
		if (rd_ctl)
			rd_data <= status;
		else if (take)
			rd_data <= rx_data; // holds until next read
	end

	// tx must hand back no more credits than it was given
	credit_bound: assert property (@(posedge clk_in) disable iff (!n_reset_in)
		credit_r <= uart_pkg::TX_CREDITS);

endmodule

//--- logic/uart_baud_tick.sv
`timescale 1ns/1ps

module uart_baud_tick (
	input  logic       clk_in,
	input  logic       n_reset_in,
	input  logic [1:0] baud_sel,
	output logic       tick
);
	logic [8:0] cnt_r;
	logic [1:0] sel_r; // last rate, to spot a change

	always_ff @(posedge clk_in or negedge n_reset_in) begin
		if (!n_reset_in) begin
			cnt_r <= uart_pkg::BAUD_DIV[0] - 9'd1;
			sel_r <= '0;
			tick  <= 1'b0;
		end else begin
			sel_r <= baud_sel;
			if (baud_sel != sel_r) begin
				cnt_r <= uart_pkg::BAUD_DIV[baud_sel] - 9'd1; // new rate, restart
				tick  <= 1'b0;
			end else if (cnt_r == '0) begin
				cnt_r <= uart_pkg::BAUD_DIV[baud_sel] - 9'd1;
				tick  <= 1'b1;
			end else begin
				cnt_r <= cnt_r - 9'd1;
				tick  <= 1'b0;
			end
		end
	end

endmodule

//--- logic/uart_tx_serializer.sv
`timescale 1ns/1ps

module uart_tx_serializer (
	input  logic               clk_in,
	input  logic               n_reset_in,
	input  logic               tick,
	input  uart_pkg::tx_load_t tx_load,
	output logic               tx,
	output logic               tx_credit
);
	uart_pkg::uart_state_e       state_r;
	logic                        pend_r; // loaded, waiting for a tick edge
	logic [uart_pkg::TICK_W-1:0] tick_cnt_r;
	logic [2:0]                  bit_cnt_r;
	logic [7:0]                  shift_r;
	logic                        par_r;
	uart_pkg::frame_fmt_t        fmt_r;
	logic [7:0]                  load_data;
	logic                        bit_end;

	assign load_data = tx_load.fmt.eight_bits ? tx_load.data : {1'b0, tx_load.data[6:0]};
	assign bit_end   = tick & (tick_cnt_r == uart_pkg::TICK_LAST);

	always_ff @(posedge clk_in) begin
		if (tx_load.valid) begin
			shift_r <= load_data;
			fmt_r   <= tx_load.fmt;
			par_r   <= ^load_data ^ (tx_load.fmt.parity_mode == uart_pkg::PAR_ODD);
		end else if (bit_end && state_r == uart_pkg::S_DATA) begin
			shift_r <= shift_r >> 1; // lsb first
		end
	end

	always_ff @(posedge clk_in or negedge n_reset_in) begin
		if (!n_reset_in) begin
			state_r    <= uart_pkg::S_IDLE;
			pend_r     <= 1'b0;
			tick_cnt_r <= '0;
			bit_cnt_r  <= '0;
			tx         <= 1'b1;
			tx_credit  <= 1'b0;
		end else begin
			tx_credit <= 1'b0;
			if (tx_load.valid)
				pend_r <= 1'b1;
			if (state_r == uart_pkg::S_IDLE) begin
				if (pend_r && tick) begin
					state_r    <= uart_pkg::S_START;
					tx         <= 1'b0; // start bit
					tick_cnt_r <= '0;
					pend_r     <= 1'b0;
				end
			end else if (tick) begin
				tick_cnt_r <= tick_cnt_r + 1'b1;
				if (bit_end) begin
					tick_cnt_r <= '0;
					case (state_r)
						uart_pkg::S_START: begin
							state_r   <= uart_pkg::S_DATA;
							tx        <= shift_r[0];
							bit_cnt_r <= '0;
						end
						uart_pkg::S_DATA: begin
							if (bit_cnt_r == {2'b11, fmt_r.eight_bits}) begin // 6 or 7
								bit_cnt_r <= '0;
								if (fmt_r.parity_mode != uart_pkg::PAR_NONE) begin
									state_r <= uart_pkg::S_PARITY;
									tx      <= par_r;
								end else begin
									state_r <= uart_pkg::S_STOP;
									tx      <= 1'b1;
								end
							end else begin
								bit_cnt_r <= bit_cnt_r + 3'd1;
								tx        <= shift_r[1];
							end
						end
						uart_pkg::S_PARITY: begin
							state_r <= uart_pkg::S_STOP;
							tx      <= 1'b1;
						end
						uart_pkg::S_STOP: begin
							if (bit_cnt_r[0] == fmt_r.two_stop) begin
								state_r   <= uart_pkg::S_IDLE;
								tx_credit <= 1'b1; // slot free again
							end else begin
								bit_cnt_r <= bit_cnt_r + 3'd1;
							end
						end
						default: state_r <= uart_pkg::S_IDLE;
					endcase
				end
			end
		end
	end

	// host side credit keeps loads out of a running frame
	load_in_idle: assert property (@(posedge clk_in) disable iff (!n_reset_in)
		tx_load.valid |-> (state_r == uart_pkg::S_IDLE) && !pend_r);

endmodule

//--- logic/uart_rx_deserializer.sv
`timescale 1ns/1ps

module uart_rx_deserializer (
	input  logic                 clk_in,
	input  logic                 n_reset_in,
	input  logic                 tick,
	input  logic                 rx,
	input  logic                 rx_en,
	input  uart_pkg::frame_fmt_t fmt,
	output uart_pkg::rx_frame_t  frame
);
	uart_pkg::uart_state_e       state_r;
	logic [1:0]                  sync_r;
	logic                        prev_r;
	logic                        rx_s;
	logic                        fall;
	logic                        sample;
	logic [uart_pkg::TICK_W-1:0] tick_cnt_r;
	logic [2:0]                  bit_cnt_r;
	logic [7:0]                  data_r;
	logic                        par_err_r;
	logic                        fe_r; // low first stop bit
	uart_pkg::frame_fmt_t        fmt_r;

	assign rx_s = sync_r[1];
	assign fall = prev_r & ~rx_s;
	// start bit is checked half way, every later bit a full bit on
	assign sample = tick & (tick_cnt_r == ((state_r == uart_pkg::S_START) ?
		uart_pkg::TICK_MID : uart_pkg::TICK_LAST));

	always_ff @(posedge clk_in or negedge n_reset_in) begin
		if (!n_reset_in) begin
			sync_r <= 2'b11; // line idles high
			prev_r <= 1'b1;
		end else begin
			sync_r <= {sync_r[0], rx};
			prev_r <= rx_s;
		end
	end

	always_ff @(posedge clk_in or negedge n_reset_in) begin
		if (!n_reset_in) begin
			state_r    <= uart_pkg::S_IDLE;
			tick_cnt_r <= '0;
			bit_cnt_r  <= '0;
			data_r     <= '0;
			par_err_r  <= 1'b0;
			fe_r       <= 1'b0;
			fmt_r      <= '0;
			frame      <= '0;
		end else begin
			frame.valid <= 1'b0;
			if (!rx_en) begin
				state_r <= uart_pkg::S_IDLE;
			end else if (state_r == uart_pkg::S_IDLE) begin
				if (fall) begin
					state_r    <= uart_pkg::S_START;
					tick_cnt_r <= '0;
					fmt_r      <= fmt; // format fixed for the whole frame
				end
			end else if (tick) begin
				tick_cnt_r <= tick_cnt_r + 1'b1;
				if (sample) begin
					tick_cnt_r <= '0;
					case (state_r)
						uart_pkg::S_START: begin
							if (rx_s) begin
								state_r <= uart_pkg::S_IDLE; // false start
							end else begin
								state_r   <= uart_pkg::S_DATA;
								bit_cnt_r <= '0;
								data_r    <= '0;
								par_err_r <= 1'b0;
								fe_r      <= 1'b0;
							end
						end
						uart_pkg::S_DATA: begin
							data_r[bit_cnt_r] <= rx_s;
							if (bit_cnt_r == {2'b11, fmt_r.eight_bits}) begin
								bit_cnt_r <= '0;
								state_r   <= (fmt_r.parity_mode != uart_pkg::PAR_NONE) ?
									uart_pkg::S_PARITY : uart_pkg::S_STOP;
							end else begin
								bit_cnt_r <= bit_cnt_r + 3'd1;
							end
						end
						uart_pkg::S_PARITY: begin
							par_err_r <= rx_s ^ ^data_r ^ (fmt_r.parity_mode == uart_pkg::PAR_ODD);
							state_r   <= uart_pkg::S_STOP;
						end
						uart_pkg::S_STOP: begin
							if (bit_cnt_r[0] == fmt_r.two_stop) begin
								state_r          <= uart_pkg::S_IDLE;
								frame.valid      <= 1'b1;
								frame.data       <= data_r;
								frame.parity_err <= par_err_r;
								frame.frame_err  <= fe_r | ~rx_s;
							end else begin
								fe_r      <= ~rx_s;
								bit_cnt_r <= bit_cnt_r + 3'd1;
							end
						end
						default: state_r <= uart_pkg::S_IDLE;
					endcase
				end
			end
		end
	end

endmodule

//--- logic/uart_rx_holding.sv
`timescale 1ns/1ps

module uart_rx_holding (
	input  logic                clk_in,
	input  logic                n_reset_in,
	input  uart_pkg::rx_frame_t frame,
	input  logic                take,
	input  logic                err_clear,
	output logic [7:0]          rx_data,
	output logic                rx_rdy,
	output logic                pe,
	output logic                fe,
	output logic                oe
);

	always_ff @(posedge clk_in) begin
		if (frame.valid)
			rx_data <= frame.data; // newest byte wins
	end

	always_ff @(posedge clk_in or negedge n_reset_in) begin
		if (!n_reset_in) begin
			rx_rdy <= 1'b0;
			pe     <= 1'b0;
			fe     <= 1'b0;
			oe     <= 1'b0;
		end else begin
			if (frame.valid)
				rx_rdy <= 1'b1;
			else if (take)
				rx_rdy <= 1'b0;
			if (err_clear) begin
				pe <= 1'b0;
				fe <= 1'b0;
				oe <= 1'b0;
			end else if (frame.valid) begin
				pe <= pe | frame.parity_err;
				fe <= fe | frame.frame_err;
				oe <= oe | (rx_rdy & ~take); // previous byte never read
			end
		end
	end

endmodule

//--- logic/uart_top.sv
`timescale 1ns/1ps

module uart_top (
	input  logic                clk_in,
	input  logic                n_reset_in,
	input  uart_pkg::host_req_t host_req,
	input  logic                rx,
	output logic [7:0]          rd_data,
	output logic                n_irq,
	output logic                tx_rdy,
	output logic                rx_rdy,
	output logic                tx
);
	uart_pkg::frame_fmt_t fmt;
	uart_pkg::tx_load_t   tx_load;
	uart_pkg::rx_frame_t  frame;
	logic [1:0]           baud_sel;
	logic [7:0]           rx_data;
	logic                 tick;
	logic                 tx_credit;
	logic                 rx_en;
	logic                 err_clear;
	logic                 take;
	logic                 pe;
	logic                 fe;
	logic                 oe;

	uart_host_regs i_regs (
		.clk_in(clk_in), .n_reset_in(n_reset_in), .host_req(host_req),
		.rx_data(rx_data), .rx_rdy(rx_rdy), .pe(pe), .fe(fe), .oe(oe),
		.tx_credit(tx_credit), .rd_data(rd_data), .fmt(fmt), .baud_sel(baud_sel),
		.tx_load(tx_load), .tx_en(), .rx_en(rx_en), .err_clear(err_clear),
		.take(take), .tx_rdy(tx_rdy), .n_irq(n_irq)
	);

	uart_baud_tick i_tick (
		.clk_in(clk_in), .n_reset_in(n_reset_in), .baud_sel(baud_sel), .tick(tick)
	);

	uart_tx_serializer i_tx (
		.clk_in(clk_in), .n_reset_in(n_reset_in), .tick(tick), .tx_load(tx_load),
		.tx(tx), .tx_credit(tx_credit)
	);

	uart_rx_deserializer i_rx (
		.clk_in(clk_in), .n_reset_in(n_reset_in), .tick(tick), .rx(rx),
		.rx_en(rx_en), .fmt(fmt), .frame(frame)
	);

	uart_rx_holding i_hold (
		.clk_in(clk_in), .n_reset_in(n_reset_in), .frame(frame), .take(take),
		.err_clear(err_clear), .rx_data(rx_data), .rx_rdy(rx_rdy), .pe(pe), .fe(fe), .oe(oe)
	);

endmodule

//--- verification/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;
	uart_pkg::host_req_t  host_req;
	uart_pkg::frame_fmt_t fmt_8n1;
	uart_pkg::frame_fmt_t fmt_7e2;
	uart_pkg::frame_fmt_t fmt_8o1;
	uart_pkg::frame_fmt_t fmt_8e1;
	logic                 clk_in;
	logic                 n_reset_in;
	logic                 rx;
	logic [7:0]           rd_data;
	logic                 n_irq;
	logic                 tx_rdy;
	logic                 rx_rdy;
	logic                 tx;
	logic [31:0]          lfsr;
	int                   errors;
	int                   cycles;

	uart_top i_dut (
		.clk_in(clk_in), .n_reset_in(n_reset_in), .host_req(host_req), .rx(rx),
		.rd_data(rd_data), .n_irq(n_irq), .tx_rdy(tx_rdy), .rx_rdy(rx_rdy), .tx(tx)
	);

	initial begin
		clk_in = 1'b0;
		forever #50 clk_in = ~clk_in;
	end

	// about 17 frames of ~5.2k cycles each plus idle gaps
	initial begin
		cycles = 0;
		while (cycles < 200000) begin
			@(posedge clk_in);
			cycles++;
		end
		$display("timeout: tests still running after %0d cycles", cycles);
		$display("Test FAILED");
		$finish;
	end

	function int bit_clks();
		return uart_pkg::BAUD_DIV[3] * uart_pkg::OVERSAMPLE; // 115200 baud
	endfunction

	function logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n ^= 32'h8020_0003;
		return n;
	endfunction

	function logic parity_bit(input logic [7:0] d, input uart_pkg::frame_fmt_t f);
		logic p;
		p = (f.parity_mode == uart_pkg::PAR_ODD);
		for (int i = 0; i < 8; i++)
			if (i < 7 || f.eight_bits)
				p ^= d[i];
		return p;
	endfunction

	function logic [7:0] mode_word(input uart_pkg::frame_fmt_t f);
		logic [7:0] w;
		w = '0;
		w[uart_pkg::MODE_BAUD +: 2]  = 2'd3;
		w[uart_pkg::MODE_EIGHT]      = f.eight_bits;
		w[uart_pkg::MODE_TWO_STOP]   = f.two_stop;
		w[uart_pkg::MODE_PARITY +: 2] = f.parity_mode;
		return w;
	endfunction

	function logic [7:0] cmd_word(input logic pe_en, fe_en, oe_en, clr);
		logic [7:0] w;
		w = '0;
		w[uart_pkg::CMD_RX_EN]   = 1'b1; // rx and tx always on
		w[uart_pkg::CMD_TX_EN]   = 1'b1;
		w[uart_pkg::CMD_PE_EN]   = pe_en;
		w[uart_pkg::CMD_FE_EN]   = fe_en;
		w[uart_pkg::CMD_OE_EN]   = oe_en;
		w[uart_pkg::CMD_CLR_ERR] = clr;
		return w;
	endfunction

	function logic [7:0] status_word(input logic rdy_rx, rdy_tx, pe, fe, oe);
		logic [7:0] w;
		w = '0;
		w[uart_pkg::ST_RX_RDY] = rdy_rx;
		w[uart_pkg::ST_TX_RDY] = rdy_tx;
		w[uart_pkg::ST_PE]     = pe;
		w[uart_pkg::ST_FE]     = fe;
		w[uart_pkg::ST_OE]     = oe;
		return w;
	endfunction

	task next_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	task compare(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (exp === act) else begin
			errors++;
			$display("Error: %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task wait_clks(input int n);
		repeat (n) @(negedge clk_in);
	endtask

	task apply_reset();
		@(posedge clk_in);
		n_reset_in <= 1'b0;
		host_req   <= '0;
		rx         <= 1'b1;
		repeat (8) @(posedge clk_in);
		n_reset_in <= 1'b1;
		@(posedge clk_in);
	endtask

	task host_write(input logic cmd, input logic [7:0] data);
		uart_pkg::host_req_t req;
		req       = '0;
		req.sel   = 1'b1;
		req.cmd   = cmd;
		req.wr    = 1'b1;
		req.wdata = data;
		@(posedge clk_in);
		host_req <= req;
		@(posedge clk_in);
		host_req <= '0;
	endtask

	task host_read(input logic cmd, output logic [7:0] data);
		uart_pkg::host_req_t req;
		req     = '0;
		req.sel = 1'b1;
		req.cmd = cmd;
		req.rd  = 1'b1;
		@(posedge clk_in);
		host_req <= req;
		@(posedge clk_in);
		host_req <= '0;
		@(negedge clk_in); // rd_data registered on the strobe edge
		data = rd_data;
	endtask

	task setup(input uart_pkg::frame_fmt_t f, input logic [7:0] cmd);
		apply_reset();
		host_write(1'b1, mode_word(f)); // first control write is the mode
		host_write(1'b1, cmd);
	endtask

	task wait_tx_rdy();
		do @(negedge clk_in); while (tx_rdy !== 1'b1);
	endtask

	task wait_rx_rdy();
		do @(negedge clk_in); while (rx_rdy !== 1'b1);
	endtask

	task hold_bit(input logic v);
		@(posedge clk_in);
		rx <= v;
		repeat (bit_clks() - 1) @(posedge clk_in);
	endtask

	task send_frame(input logic [7:0] d, input uart_pkg::frame_fmt_t f,
		input logic bad_par, input logic bad_stop);
		hold_bit(1'b0);
		for (int i = 0; i < (f.eight_bits ? 8 : 7); i++)
			hold_bit(d[i]);
		if (f.parity_mode != uart_pkg::PAR_NONE)
			hold_bit(parity_bit(d, f) ^ bad_par);
		for (int i = 0; i < (f.two_stop ? 2 : 1); i++)
			hold_bit(!(bad_stop && i == 0));
		@(posedge clk_in);
		rx <= 1'b1; // idle again after a low stop bit
	endtask

	task expect_tx_frame(input logic [7:0] exp, input uart_pkg::frame_fmt_t f);
		logic [7:0] got;
		got = '0;
		do @(negedge clk_in); while (tx !== 1'b0);
		wait_clks(bit_clks() / 2); // center of start bit
		compare("tx start bit", 8'h00, {7'h0, tx});
		for (int i = 0; i < (f.eight_bits ? 8 : 7); i++) begin
			wait_clks(bit_clks());
			got[i] = tx;
		end
		compare("tx data", f.eight_bits ? exp : {1'b0, exp[6:0]}, got);
		if (f.parity_mode != uart_pkg::PAR_NONE) begin
			wait_clks(bit_clks());
			compare("tx parity bit", {7'h0, parity_bit(exp, f)}, {7'h0, tx});
		end
		for (int i = 0; i < (f.two_stop ? 2 : 1); i++) begin
			wait_clks(bit_clks());
			compare("tx stop bit", 8'h01, {7'h0, tx});
		end
		compare("tx_rdy", 8'h00, {7'h0, tx_rdy}); // frame still running in its last stop bit
	endtask

	task check_reset_state();
		logic [7:0] st;
		apply_reset();
		@(negedge clk_in);
		compare("tx", 8'h01, {7'h0, tx});
		compare("tx_rdy", 8'h00, {7'h0, tx_rdy});
		compare("rx_rdy", 8'h00, {7'h0, rx_rdy});
		compare("n_irq", 8'h01, {7'h0, n_irq});
		host_read(1'b1, st);
		compare("status", 8'h00, st);
	endtask

	task transmit_format(input uart_pkg::frame_fmt_t f, input int n);
		logic [7:0] b;
		setup(f, cmd_word(1'b0, 1'b0, 1'b0, 1'b0));
		repeat (n) begin
			next_byte(b);
			host_write(1'b0, b);
			@(negedge clk_in);
			compare("tx_rdy", 8'h00, {7'h0, tx_rdy}); // credit taken
			expect_tx_frame(b, f);
			wait_tx_rdy();
		end
	endtask

	task transmit_credit();
		logic [7:0] a;
		logic [7:0] b;
		int         lows;
		setup(fmt_8n1, cmd_word(1'b0, 1'b0, 1'b0, 1'b0));
		next_byte(a);
		next_byte(b);
		host_write(1'b0, a);
		host_write(1'b0, b); // no credit left, dropped
		expect_tx_frame(a, fmt_8n1);
		wait_tx_rdy();
		lows = 0;
		repeat (bit_clks() * 12) begin
			@(negedge clk_in);
			if (tx !== 1'b1)
				lows++;
		end
		assert (lows == 0) else begin
			errors++;
			$display("a data write without a credit was still sent on tx");
		end
	endtask

	task receive_format(input uart_pkg::frame_fmt_t f, input int n);
		logic [7:0] b;
		logic [7:0] got;
		setup(f, cmd_word(1'b0, 1'b0, 1'b0, 1'b0));
		repeat (n) begin
			next_byte(b);
			send_frame(b, f, 1'b0, 1'b0);
			wait_rx_rdy();
			host_read(1'b0, got);
			compare("rd_data", f.eight_bits ? b : {1'b0, b[6:0]}, got);
			compare("rx_rdy", 8'h00, {7'h0, rx_rdy});
			host_read(1'b1, got);
			compare("status", status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), got);
		end
	endtask

	task error_flags_irq();
		logic [7:0] b;
		logic [7:0] got;
		setup(fmt_8e1, cmd_word(1'b0, 1'b1, 1'b0, 1'b0)); // only frame errors interrupt
		next_byte(b);
		send_frame(b, fmt_8e1, 1'b1, 1'b0);
		wait_rx_rdy();
		host_read(1'b0, got);
		compare("rd_data", b, got);
		compare("n_irq", 8'h01, {7'h0, n_irq});
		host_read(1'b1, got);
		compare("status", status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), got);
		next_byte(b);
		send_frame(b, fmt_8e1, 1'b0, 1'b1);
		wait_rx_rdy();
		host_read(1'b0, got);
		compare("rd_data", b, got);
		compare("n_irq", 8'h00, {7'h0, n_irq});
		host_read(1'b1, got);
		compare("status", status_word(1'b0, 1'b1, 1'b1, 1'b1, 1'b0), got);
		host_write(1'b1, cmd_word(1'b0, 1'b1, 1'b0, 1'b1));
		host_read(1'b1, got);
		compare("status", status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), got);
		compare("n_irq", 8'h01, {7'h0, n_irq});
	endtask

	task receive_overrun();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] got;
		setup(fmt_8n1, cmd_word(1'b0, 1'b0, 1'b0, 1'b0));
		next_byte(a);
		next_byte(b);
		send_frame(a, fmt_8n1, 1'b0, 1'b0);
		send_frame(b, fmt_8n1, 1'b0, 1'b0); // first byte never read
		wait_rx_rdy();
		host_read(1'b1, got);
		compare("status", status_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b1), got);
		compare("n_irq", 8'h01, {7'h0, n_irq});
		host_write(1'b1, cmd_word(1'b0, 1'b0, 1'b1, 1'b0));
		@(negedge clk_in);
		compare("n_irq", 8'h00, {7'h0, n_irq});
		host_read(1'b0, got);
		compare("rd_data", b, got);
	endtask

	initial begin
		host_req   = '0;
		rx         = 1'b1;
		n_reset_in = 1'b0;
		lfsr       = 32'h2d9b;
		errors     = 0;
		fmt_8n1 = '{two_stop: 1'b0, eight_bits: 1'b1, parity_mode: uart_pkg::PAR_NONE};
		fmt_7e2 = '{two_stop: 1'b1, eight_bits: 1'b0, parity_mode: uart_pkg::PAR_EVEN};
		fmt_8o1 = '{two_stop: 1'b0, eight_bits: 1'b1, parity_mode: uart_pkg::PAR_ODD};
		fmt_8e1 = '{two_stop: 1'b0, eight_bits: 1'b1, parity_mode: uart_pkg::PAR_EVEN};
		check_reset_state();
		transmit_format(fmt_8n1, 2);
		transmit_format(fmt_7e2, 2);
		transmit_format(fmt_8o1, 2);
		transmit_credit();
		receive_format(fmt_8n1, 2);
		receive_format(fmt_7e2, 2);
		receive_format(fmt_8o1, 2);
		error_flags_irq();
		receive_overrun();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- flist.f
logic/uart_pkg.sv
logic/uart_host_regs.sv
logic/uart_baud_tick.sv
logic/uart_tx_serializer.sv
logic/uart_rx_deserializer.sv
logic/uart_rx_holding.sv
logic/uart_top.sv
verification/uart_tb.sv
